//--- Makefile
VERILATOR := verilator
TOP       := tb_memory_unit
FILELIST  := verilog.f
FLAGS     := --binary --timing --assert
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Verification failed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation run reported failure"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- source/data_cache.sv
`default_nettype none

`include "mem_defs.svh"

module data_cache (
    input  logic              clk,
    input  logic              arst_n,
    input  mem_pkg::mem_req_t req,
    input  logic [`XLEN-1:0]  mem_word,
    output logic [`XLEN-1:0]  cache_word,
    output logic              hit
);

    import mem_pkg::*;

    localparam int IDX_W = $clog2(`CACHE_LINES);
    localparam int TAG_W = $clog2(`DMEM_WORDS) - IDX_W;

    logic [`CACHE_LINES-1:0] valid;
    logic [TAG_W-1:0]        tags  [`CACHE_LINES];
    logic [`XLEN-1:0]        lines [`CACHE_LINES];

    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic             tag_match;
    logic             refill;
    logic             invalidate;

    assign idx = req.addr[IDX_W+1:2];
    assign tag = req.addr[IDX_W+TAG_W+1:IDX_W+2];

    assign tag_match = tags[idx] == tag;
    assign hit       = valid[idx] && tag_match;

    // Miss passes the memory word straight through
    assign cache_word = hit ? lines[idx] : mem_word;

    assign refill     = !req.we && !hit; // Read miss fills the line
    assign invalidate = req.we && hit;   // Write-through without allocate

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
        end else if (invalidate) begin
            valid[idx] <= 1'b0;
        end else if (refill) begin
            valid[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (refill) begin
            tags[idx]  <= tag;
            lines[idx] <= mem_word;
        end
    end

endmodule

`default_nettype wire

//--- source/data_mem.sv
`default_nettype none

`include "mem_defs.svh"

module data_mem (
    input  logic              clk,
    input  mem_pkg::mem_req_t req,
    output logic [`XLEN-1:0]  mem_word
);

    import mem_pkg::*;

    localparam int WIDX_W = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0] ram [`DMEM_WORDS];

    logic [WIDX_W-1:0] widx;
    logic [1:0]        lane;
    data_word_u        cur_word;
    data_word_u        new_word;
    logic              store_op;
    logic              do_store;

    assign widx = req.addr[WIDX_W+1:2]; // Upper address bits ignored
    assign lane = req.addr[1:0];

    always_comb begin
        cur_word.word = ram[widx];
        new_word      = cur_word;
        store_op      = 1'b1;
        case (req.op)
            OP_SB: begin
                new_word.bytes[lane] = req.wdata[7:0];
            end
            OP_SH: begin
                new_word.halves[lane[1]] = req.wdata[15:0]; // Half picked by addr[1]
            end
            OP_SW: begin
                new_word.word = req.wdata;
            end
            default: begin
                store_op = 1'b0; // Not a store code
            end
        endcase
    end

    assign do_store = req.we && store_op;

    always_ff @(posedge clk) begin
        if (do_store) begin
            ram[widx] <= new_word.word;
        end
    end

    assign mem_word = cur_word.word; // Combinational read

    // A write request must carry a defined access code
    assert property (@(posedge clk) req.we |-> !$isunknown(req.op))
        else $error("data_mem: unknown op on write at %0t", $time);

endmodule

`default_nettype wire

//--- source/load_align.sv
`default_nettype none

`include "mem_defs.svh"

module load_align (
    input  mem_pkg::mem_op_e  op,
    input  logic [1:0]        byte_sel,
    input  logic [`XLEN-1:0]  word,
    output logic [`XLEN-1:0]  rd
);

    import mem_pkg::*;

    data_word_u w;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    always_comb begin
        w.word   = word;
        sel_byte = w.bytes[byte_sel];
        sel_half = w.halves[byte_sel[1]]; // Offset 0 or 2
    end

    always_comb begin
        case (op)
            OP_LB: begin
                rd = {{(`XLEN-8){sel_byte[7]}}, sel_byte};
            end
            OP_LH: begin
                rd = {{(`XLEN-16){sel_half[15]}}, sel_half};
            end
            OP_LW: begin
                rd = w.word;
            end
            OP_LBU: begin
                rd = {{(`XLEN-8){1'b0}}, sel_byte};
            end
            OP_LHU: begin
                rd = {{(`XLEN-16){1'b0}}, sel_half};
            end
            default: begin
                rd = '0; // 011, 110, 111
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Data and address width
`define XLEN 32

// Data memory size in 32-bit words, word index taken from addr[9:2]
`define DMEM_WORDS 256

// One-word lines, index from addr[5:2] and tag from addr[9:6]
`define CACHE_LINES 16

`endif

//--- source/mem_pkg.sv
`default_nettype none

`include "mem_defs.svh"

package mem_pkg;

    // funct3 codes of the load and store instructions
    typedef enum logic [2:0] {
        OP_LB  = 3'b000,
        OP_LH  = 3'b001,
        OP_LW  = 3'b010,
        OP_LBU = 3'b100,
        OP_LHU = 3'b101
    } mem_op_e;

    // Stores share their encodings with the signed loads
    localparam mem_op_e OP_SB = OP_LB;
    localparam mem_op_e OP_SH = OP_LH;
    localparam mem_op_e OP_SW = OP_LW;

    typedef struct packed {
        logic             we;    // Store when high, load otherwise
        mem_op_e          op;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
    } mem_req_t;

    // One data word, seen whole or by byte and half lanes
    typedef union packed {
        logic [`XLEN-1:0] word;
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } data_word_u;

endpackage

`default_nettype wire

//--- source/memory_unit.sv
`default_nettype none

`include "mem_defs.svh"

module memory_unit (
    input  logic              clk,
    input  logic              arst_n,
    input  mem_pkg::mem_req_t req,
    output logic [`XLEN-1:0]  rd,
    output logic              hit
);

    import mem_pkg::*;

    logic [`XLEN-1:0] mem_word;
    logic [`XLEN-1:0] cache_word;

    data_mem i_data_mem (
        .clk      (clk),
        .req      (req),
        .mem_word (mem_word)
    );

    data_cache i_data_cache (
        .clk        (clk),
        .arst_n     (arst_n),
        .req        (req),
        .mem_word   (mem_word),
        .cache_word (cache_word),
        .hit        (hit)
    );

    load_align i_load_align (
        .op       (req.op),
        .byte_sel (req.addr[1:0]),
        .word     (cache_word),
        .rd       (rd)
    );

    // Cached copy stays coherent with the RAM on every read hit
    assert property (@(posedge clk) disable iff (!arst_n)
        (hit && !req.we) |-> cache_word == mem_word)
        else $error("memory_unit: stale cache word at %0t", $time);

endmodule

`default_nettype wire

//--- tests/mem_checker.sv
`default_nettype none

`include "mem_defs.svh"

module mem_checker (
    input  logic              clk,
    input  logic              arst_n,
    input  mem_pkg::mem_req_t req,
    input  logic [`XLEN-1:0]  rd,
    input  logic              hit,
    output int                load_count,
    output int                error_count
);

    import mem_pkg::*;

    logic [`XLEN-1:0]        shadow_mem [`DMEM_WORDS];
    logic [`CACHE_LINES-1:0] shadow_valid;
    logic [3:0]              shadow_tag [`CACHE_LINES];
    int                      loads = 0;
    int                      errors = 0;

    assign load_count  = loads;
    assign error_count = errors;

    // RV32I load result taken from a memory word
    function automatic logic [`XLEN-1:0] expected_load(input logic [2:0] code,
                                                       input logic [1:0] offset,
                                                       input logic [`XLEN-1:0] w);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[{offset, 3'b000} +: 8];
        h = w[{offset[1], 4'b0000} +: 16];
        case (code)
            3'b000:  expected_load = {{24{b[7]}}, b};
            3'b001:  expected_load = {{16{h[15]}}, h};
            3'b010:  expected_load = w;
            3'b100:  expected_load = {24'h0, b};
            3'b101:  expected_load = {16'h0, h};
            default: expected_load = '0;
        endcase
    endfunction

    always @(posedge clk or negedge arst_n) begin : compare
        logic [7:0]       widx;
        logic [3:0]       idx;
        logic [3:0]       tag;
        logic             exp_hit;
        logic [`XLEN-1:0] exp_rd;
        if (!arst_n) begin
            shadow_valid = '0;
        end else begin
            widx    = req.addr[9:2];
            idx     = req.addr[5:2];
            tag     = req.addr[9:6];
            exp_hit = shadow_valid[idx] && (shadow_tag[idx] == tag);
            if (hit !== exp_hit) begin
                $display("MISMATCH at %0t: hit %b, expected %b, addr %h", $time, hit,
                         exp_hit, req.addr);
                errors++;
            end
            if (!req.we) begin
                loads++;
                exp_rd = expected_load(req.op, req.addr[1:0], shadow_mem[widx]);
                if (rd !== exp_rd) begin
                    $display("MISMATCH at %0t: op %b addr %h rd %h, expected %h", $time,
                             req.op, req.addr, rd, exp_rd);
                    errors++;
                end
                if (!exp_hit) begin
                    shadow_valid[idx] = 1'b1; // Read miss refills
                    shadow_tag[idx]   = tag;
                end
            end else begin
                case (req.op)
                    3'b000: shadow_mem[widx][{req.addr[1:0], 3'b000} +: 8] = req.wdata[7:0];
                    3'b001: shadow_mem[widx][{req.addr[1], 4'b0000} +: 16] = req.wdata[15:0];
                    3'b010: shadow_mem[widx] = req.wdata;
                    default: ;
                endcase
                if (exp_hit) begin
                    shadow_valid[idx] = 1'b0; // Write hit drops the line
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_memory_unit.sv
`default_nettype none

`include "mem_defs.svh"

module tb_memory_unit;

    import mem_pkg::*;

    localparam int WAIT_CYCLES = 20;

    logic             clk;
    logic             arst_n;
    mem_req_t         req;
    logic [`XLEN-1:0] rd;
    logic             hit;
    int               load_count;
    int               error_count;
    int               loads_issued = 0;
    int               timeout_count = 0;

    memory_unit i_memory_unit (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .rd     (rd),
        .hit    (hit)
    );

    mem_checker i_mem_checker (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .rd          (rd),
        .hit         (hit),
        .load_count  (load_count),
        .error_count (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Initial RAM contents unique per word index
    function automatic logic [`XLEN-1:0] fill_pattern(input int i);
        logic [7:0] k;
        k = i[7:0];
        return {k ^ 8'h3c, ~k, k, {k[3:0], k[7:4]} ^ 8'ha5};
    endfunction

    task automatic drive_req(input logic we, input logic [2:0] code,
                             input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] wdata);
        @(negedge clk);
        req.we    = we;
        req.op    = mem_op_e'(code);
        req.addr  = addr;
        req.wdata = wdata;
        if (!we) begin
            loads_issued++;
        end
    endtask

    task automatic drive_idle();
        drive_req(1'b1, 3'b011, '0, '0); // Write without a store code leaves the RAM alone
    endtask

    task automatic wait_for_checks();
        int cycles;
        cycles = 0;
        while (load_count < loads_issued && cycles < WAIT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (load_count < loads_issued) begin
            $display("Timeout: checker saw %0d of %0d loads", load_count, loads_issued);
            timeout_count++;
        end
    endtask

    initial begin
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] a_addr;
        logic [2:0]       code;
        arst_n    = 1'b0;
        req.we    = 1'b1;
        req.op    = mem_op_e'(3'b011);
        req.addr  = '0;
        req.wdata = '0;
        void'($urandom(32'hc0a2));
        repeat (8) @(negedge clk);
        arst_n = 1'b1;

        for (int i = 0; i < `DMEM_WORDS; i++) begin
            drive_req(1'b1, 3'b010, i << 2, fill_pattern(i));
        end

        drive_req(1'b0, 3'b010, 32'h10, '0); // First read misses
        drive_req(1'b0, 3'b010, 32'h10, '0); // Then hits

        for (int n = 0; n < 8; n++) begin
            addr = $urandom & 32'hffff_fffc;
            drive_req(1'b1, 3'b010, addr, $urandom);
            drive_req(1'b0, 3'b010, addr, '0);
        end

        for (int off = 0; off < 4; off++) begin
            drive_req(1'b1, 3'b000, 32'h200 + off, 32'hffff_ff80 | off);
            drive_req(1'b0, 3'b010, 32'h200, '0);
        end
        for (int off = 0; off < 4; off += 2) begin
            drive_req(1'b1, 3'b001, 32'h240 + off, 32'h1234_8000 | off);
            drive_req(1'b0, 3'b010, 32'h240, '0);
        end

        drive_req(1'b1, 3'b010, 32'h280, 32'h8f7e_c180);
        for (int c = 0; c < 8; c++) begin
            for (int off = 0; off < 4; off++) begin
                drive_req(1'b0, 3'(c), 32'h280 + off, '0);
            end
        end

        a_addr = 32'h120;
        drive_req(1'b1, 3'b010, a_addr, 32'h0bad_cafe);
        drive_req(1'b0, 3'b010, a_addr, '0);
        drive_req(1'b0, 3'b010, a_addr, '0);
        drive_req(1'b1, 3'b010, a_addr, 32'hfeed_0001); // Invalidates the line
        drive_req(1'b0, 3'b010, a_addr, '0);
        drive_req(1'b0, 3'b010, a_addr, '0);
        drive_req(1'b0, 3'b010, a_addr ^ 32'h40, '0); // Same index with another tag
        drive_req(1'b0, 3'b010, a_addr, '0);

        for (int n = 0; n < 400; n++) begin
            addr      = $urandom;
            addr[9:2] = 8'($urandom_range(0, 31));
            if ($urandom_range(0, 9) < 4) begin
                code = 3'($urandom_range(0, 2));
                drive_req(1'b1, code, addr, $urandom);
            end else begin
                code = 3'($urandom_range(0, 7));
                drive_req(1'b0, code, addr, '0);
            end
        end

        drive_idle();
        wait_for_checks();

        $display("Checked %0d loads: %0d mismatches, %0d timeouts", load_count, error_count,
                 timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+source
source/mem_pkg.sv
source/data_mem.sv
source/data_cache.sv
source/load_align.sv
source/memory_unit.sv
tests/mem_checker.sv
tests/tb_memory_unit.sv
